/* design/alu.sv */
`timescale 1ns/10ps

module alu (
    input  logic                  CK_REF,
    input  logic                  RST_N,
    input  rv_core_pkg::ex_ctrl_t ex_ctrl,
    input  rv_core_pkg::xlen_t    op_a,
    input  rv_core_pkg::xlen_t    op_b,
    input  rv_core_pkg::xlen_t    store_data,
    output rv_core_pkg::ex_ctrl_t mem_ctrl,         // Control word one stage on
    output rv_core_pkg::xlen_t    alu_result,
    output rv_core_pkg::xlen_t    mem_store_data
);

    import rv_core_pkg::*;

    xlen_t      result_d;
    logic [4:0] shamt;

    assign shamt = op_b[4:0];                       // RV32 shift amount

    // ********************
    // Operations
    // ********************
    always_comb begin
        case (ex_ctrl.alu_op)
            ALU_ADD:  result_d = op_a + op_b;       // Also load/store address
            ALU_SUB:  result_d = op_a - op_b;
            ALU_SLL:  result_d = op_a << shamt;
            ALU_SLT:  result_d = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: result_d = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:  result_d = op_a ^ op_b;
            ALU_SRL:  result_d = op_a >> shamt;
            ALU_SRA:  result_d = xlen_t'($signed(op_a) >>> shamt);
            ALU_OR:   result_d = op_a | op_b;
            ALU_AND:  result_d = op_a & op_b;
            default:  result_d = '0;                // Bubble
        endcase
    end

    always_ff @(posedge CK_REF or negedge RST_N) begin
        if (!RST_N) begin
            mem_ctrl <= CTRL_BUBBLE;
        end else begin
            mem_ctrl <= ex_ctrl;
        end
    end

    always_ff @(posedge CK_REF) begin
        alu_result     <= result_d;
        mem_store_data <= store_data;
    end

endmodule

/* design/fetch_stage.sv */
`timescale 1ns/10ps

module fetch_stage #(
    parameter rv_core_pkg::xlen_t RESET_PC = '0     // First fetch address
) (
    input  logic                   CK_REF,
    input  logic                   RST_N,
    input  rv_core_pkg::xlen_t     inst_data,       // Word at inst_addr, same cycle
    output rv_core_pkg::xlen_t     inst_addr,       // Program counter
    output rv_core_pkg::inst_word_t inst_reg        // Instruction register
);

    import rv_core_pkg::*;

    localparam xlen_t PC_STEP = xlen_t'(4);         // One 32-bit instruction

    // ********************
    // Program counter
    // ********************
    always_ff @(posedge CK_REF or negedge RST_N) begin
        if (!RST_N) begin
            inst_addr <= RESET_PC;
        end else begin
            inst_addr <= inst_addr + PC_STEP;       // No branches, so always sequential
        end
    end

    // Instruction register, zero opcode decodes as a bubble
    always_ff @(posedge CK_REF or negedge RST_N) begin
        if (!RST_N) begin
            inst_reg <= '0;
        end else begin
            inst_reg <= inst_data;
        end
    end

endmodule

/* design/inst_decoder.sv */
`timescale 1ns/10ps

module inst_decoder (
    input  logic                    CK_REF,
    input  logic                    RST_N,
    input  rv_core_pkg::inst_word_t inst_reg,
    output rv_core_pkg::reg_idx_t   rs1_idx,
    output rv_core_pkg::reg_idx_t   rs2_idx,
    input  rv_core_pkg::xlen_t      rs1_data,
    input  rv_core_pkg::xlen_t      rs2_data,
    output rv_core_pkg::ex_ctrl_t   ex_ctrl,        // Execute register, control half
    output rv_core_pkg::xlen_t      op_a,
    output rv_core_pkg::xlen_t      op_b,
    output rv_core_pkg::xlen_t      store_data      // rs2 value for stores
);

    import rv_core_pkg::*;

    ex_ctrl_t ctrl_d;
    xlen_t    op_a_d;
    xlen_t    op_b_d;
    xlen_t    store_d;
    xlen_t    imm_i;
    xlen_t    imm_s;
    logic     legal;                                // Opcode and funct3 understood

    // funct3 to ALU op, shared by OP and OP_IMM
    function automatic alu_op_e alu_from_funct3(input logic [2:0] funct3,
                                                input logic       alt,
                                                input logic       sub_ok);
        alu_op_e op;
        case (funct3)
            3'b000:  op = (alt && sub_ok) ? ALU_SUB : ALU_ADD;  // No SUBI
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // rs1 and rs2 sit in the same bits in every kept format
    assign rs1_idx = inst_reg.r.rs1;
    assign rs2_idx = inst_reg.r.rs2;

    assign imm_i = {{(XLEN-12){inst_reg.i.imm[11]}}, inst_reg.i.imm};
    assign imm_s = {{(XLEN-12){inst_reg.s.imm_hi[6]}}, inst_reg.s.imm_hi, inst_reg.s.imm_lo};

    // ********************
    // Decode
    // ********************
    always_comb begin
        legal   = 1'b1;
        ctrl_d  = CTRL_BUBBLE;
        op_a_d  = rs1_data;                         // Every kept format reads rs1
        op_b_d  = '0;
        store_d = '0;
        case (inst_reg.r.opcode)
            OPC_OP: begin
                ctrl_d.alu_op = alu_from_funct3(inst_reg.r.funct3, inst_reg.r.funct7[5], 1'b1);
                ctrl_d.wb_en  = 1'b1;
                ctrl_d.rd     = inst_reg.r.rd;
                op_b_d        = rs2_data;
            end
            OPC_OP_IMM: begin
                // imm[10] is instruction bit 30, SRAI vs SRLI
                ctrl_d.alu_op = alu_from_funct3(inst_reg.i.funct3, inst_reg.i.imm[10], 1'b0);
                ctrl_d.wb_en  = 1'b1;
                ctrl_d.rd     = inst_reg.i.rd;
                op_b_d        = imm_i;              // ALU keeps only [4:0] for shifts
            end
            OPC_LOAD: begin
                ctrl_d.alu_op      = ALU_ADD;       // Address = rs1 + imm
                ctrl_d.mem_op      = MEM_LOAD;
                ctrl_d.wb_en       = 1'b1;
                ctrl_d.wb_from_mem = 1'b1;
                ctrl_d.rd          = inst_reg.i.rd;
                op_b_d             = imm_i;
                case (inst_reg.i.funct3)
                    3'b000:  ctrl_d.data_type = DT_BYTE_SIGNED;     // LB
                    3'b001:  ctrl_d.data_type = DT_HALF_SIGNED;     // LH
                    3'b010:  ctrl_d.data_type = DT_WORD;            // LW
                    3'b100:  ctrl_d.data_type = DT_BYTE_UNSIGNED;   // LBU
                    3'b101:  ctrl_d.data_type = DT_HALF_UNSIGNED;   // LHU
                    default: legal = 1'b0;
                endcase
            end
            OPC_STORE: begin
                ctrl_d.alu_op = ALU_ADD;
                ctrl_d.mem_op = MEM_STORE;
                op_b_d        = imm_s;
                store_d       = rs2_data;
                case (inst_reg.s.funct3)
                    3'b000:  ctrl_d.data_type = DT_BYTE_SIGNED;     // SB
                    3'b001:  ctrl_d.data_type = DT_HALF_SIGNED;     // SH
                    3'b010:  ctrl_d.data_type = DT_WORD;            // SW
                    default: legal = 1'b0;
                endcase
            end
            default: legal = 1'b0;                  // LUI, JAL, branches etc. become bubbles
        endcase

        if (!legal) begin
            ctrl_d  = CTRL_BUBBLE;
            op_a_d  = '0;
            op_b_d  = '0;
            store_d = '0;
        end
    end

    // ********************
    // Execute register
    // ********************
    always_ff @(posedge CK_REF or negedge RST_N) begin
        if (!RST_N) begin
            ex_ctrl <= CTRL_BUBBLE;
        end else begin
            ex_ctrl <= ctrl_d;
        end
    end

    always_ff @(posedge CK_REF) begin
        op_a       <= op_a_d;
        op_b       <= op_b_d;
        store_data <= store_d;
    end

endmodule

/* design/mem_wb_stage.sv */
`timescale 1ns/10ps

module mem_wb_stage #(
    parameter int MEM_AW = 16                       // Data address width
) (
    input  logic                  CK_REF,
    input  logic                  RST_N,
    input  rv_core_pkg::ex_ctrl_t mem_ctrl,
    input  rv_core_pkg::xlen_t    alu_result,
    input  rv_core_pkg::xlen_t    mem_store_data,
    output logic                  mem_read_wrn,     // Low only in a store cycle
    output logic [MEM_AW-1:0]     mem_addr,
    output rv_core_pkg::xlen_t    mem_wdata,
    input  rv_core_pkg::xlen_t    mem_rdata,        // Combinational from mem_addr
    output logic                  wr_en,
    output rv_core_pkg::reg_idx_t wr_idx,
    output rv_core_pkg::xlen_t    wr_data
);

    import rv_core_pkg::*;

    ex_ctrl_t wb_ctrl;
    xlen_t    wb_rdata;
    xlen_t    wb_result;

    // Width and sign adjust, used for both store and load data
    function automatic xlen_t extend(input xlen_t data, input data_type_e dtype);
        case (dtype)
            DT_HALF_UNSIGNED: return {{(XLEN-16){1'b0}}, data[15:0]};
            DT_HALF_SIGNED:   return {{(XLEN-16){data[15]}}, data[15:0]};
            DT_BYTE_UNSIGNED: return {{(XLEN-8){1'b0}}, data[7:0]};
            DT_BYTE_SIGNED:   return {{(XLEN-8){data[7]}}, data[7:0]};
            default:          return data;
        endcase
    endfunction

    // ********************
    // Memory access
    // ********************
    always_comb begin
        mem_read_wrn = 1'b1;                        // Idle looks like a read
        mem_addr     = '0;
        mem_wdata    = '0;
        case (mem_ctrl.mem_op)
            MEM_LOAD: begin
                mem_addr = alu_result[MEM_AW-1:0];
            end
            MEM_STORE: begin
                mem_read_wrn = 1'b0;
                mem_addr     = alu_result[MEM_AW-1:0];
                mem_wdata    = extend(mem_store_data, mem_ctrl.data_type);  // SB/SH sign-extend
            end
            default: begin
                mem_addr = '0;
            end
        endcase
    end

    // ********************
    // Write-back
    // ********************
    always_ff @(posedge CK_REF or negedge RST_N) begin
        if (!RST_N) begin
            wb_ctrl <= CTRL_BUBBLE;
        end else begin
            wb_ctrl <= mem_ctrl;
        end
    end

    always_ff @(posedge CK_REF) begin
        wb_rdata  <= mem_rdata;                     // Sampled every cycle, used on loads
        wb_result <= alu_result;
    end

    assign wr_en   = wb_ctrl.wb_en;
    assign wr_idx  = wb_ctrl.rd;
    assign wr_data = wb_ctrl.wb_from_mem ? extend(wb_rdata, wb_ctrl.data_type) : wb_result;

endmodule

/* design/reg_file.sv */
`timescale 1ns/10ps

module reg_file (
    input  logic                  CK_REF,
    input  logic                  RST_N,
    input  rv_core_pkg::reg_idx_t rs1_idx,
    input  rv_core_pkg::reg_idx_t rs2_idx,
    output rv_core_pkg::xlen_t    rs1_data,         // Asynchronous read
    output rv_core_pkg::xlen_t    rs2_data,
    input  logic                  wr_en,
    input  rv_core_pkg::reg_idx_t wr_idx,
    input  rv_core_pkg::xlen_t    wr_data
);

    import rv_core_pkg::*;

    xlen_t regs [NUM_REGS];

    // No bypass from the write port, program keeps four-instruction spacing
    assign rs1_data = regs[rs1_idx];
    assign rs2_data = regs[rs2_idx];

    always_ff @(posedge CK_REF or negedge RST_N) begin
        if (!RST_N) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin  // x0 stays zero
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

/* design/rv_core_pkg.sv */
package rv_core_pkg;

    localparam int XLEN     = 32;              // Integer word width
    localparam int REG_AW   = 5;               // Register index width
    localparam int NUM_REGS = 2 ** REG_AW;     // x0..x31

    typedef logic [XLEN-1:0]   xlen_t;
    typedef logic [REG_AW-1:0] reg_idx_t;

    // ********************
    // Encodings
    // ********************
    typedef enum logic [6:0] {
        OPC_OP     = 7'b011_0011,              // ADD, SUB, SLL ... AND
        OPC_OP_IMM = 7'b001_0011,              // ADDI ... SRAI
        OPC_LOAD   = 7'b000_0011,              // LB, LH, LW, LBU, LHU
        OPC_STORE  = 7'b010_0011               // SB, SH, SW
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_SLL  = 4'h2,
        ALU_SLT  = 4'h3,
        ALU_SLTU = 4'h4,
        ALU_XOR  = 4'h5,
        ALU_SRL  = 4'h6,
        ALU_SRA  = 4'h7,
        ALU_OR   = 4'h8,
        ALU_AND  = 4'h9,
        ALU_NOP  = 4'hF                        // Result forced to zero
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NOP   = 2'b00,                     // Zero so a cleared word is idle
        MEM_LOAD  = 2'b01,
        MEM_STORE = 2'b10
    } mem_op_e;

    typedef enum logic [2:0] {
        DT_WORD          = 3'b000,
        DT_HALF_UNSIGNED = 3'b001,
        DT_HALF_SIGNED   = 3'b010,
        DT_BYTE_UNSIGNED = 3'b011,
        DT_BYTE_SIGNED   = 3'b100
    } data_type_e;

    // ********************
    // Instruction formats
    // ********************
    typedef struct packed {
        logic [6:0] funct7;                    // Bit 30 picks SUB and SRA
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;                      // imm[11:0]
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_hi;                    // imm[11:5]
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;                    // imm[4:0]
        logic [6:0] opcode;
    } s_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
    } inst_word_t;

    // Control word that rides along with each instruction
    typedef struct packed {
        alu_op_e    alu_op;
        mem_op_e    mem_op;
        data_type_e data_type;                 // Access width and sign
        logic       wb_en;                     // Write rd at the end
        logic       wb_from_mem;               // Load data instead of ALU result
        reg_idx_t   rd;
    } ex_ctrl_t;

    localparam ex_ctrl_t CTRL_BUBBLE = '{
        alu_op:      ALU_NOP,
        mem_op:      MEM_NOP,
        data_type:   DT_WORD,
        wb_en:       1'b0,
        wb_from_mem: 1'b0,
        rd:          '0
    };

endpackage

/* design/rv_core_top.sv */
`timescale 1ns/10ps

module rv_core_top #(
    parameter rv_core_pkg::xlen_t RESET_PC = '0,    // Reset fetch address
    parameter int                 MEM_AW   = 16     // Data bus address width
) (
    input  logic               CK_REF,
    input  logic               RST_N,
    output rv_core_pkg::xlen_t inst_addr,
    input  rv_core_pkg::xlen_t inst_data,
    output logic               mem_read_wrn,
    output logic [MEM_AW-1:0]  mem_addr,
    output rv_core_pkg::xlen_t mem_wdata,
    input  rv_core_pkg::xlen_t mem_rdata
);

    import rv_core_pkg::*;

    inst_word_t inst_reg;
    reg_idx_t   rs1_idx;
    reg_idx_t   rs2_idx;
    xlen_t      rs1_data;
    xlen_t      rs2_data;
    ex_ctrl_t   ex_ctrl;                            // Decode to ALU
    xlen_t      op_a;
    xlen_t      op_b;
    xlen_t      store_data;
    ex_ctrl_t   mem_ctrl;                           // ALU to memory stage
    xlen_t      alu_result;
    xlen_t      mem_store_data;
    logic       wr_en;                              // Write-back port
    reg_idx_t   wr_idx;
    xlen_t      wr_data;

    fetch_stage #(.RESET_PC(RESET_PC)) i_fetch (
        .CK_REF(CK_REF), .RST_N(RST_N), .inst_data(inst_data),
        .inst_addr(inst_addr), .inst_reg(inst_reg)
    );

    inst_decoder i_decoder (
        .CK_REF(CK_REF), .RST_N(RST_N), .inst_reg(inst_reg),
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .ex_ctrl(ex_ctrl), .op_a(op_a), .op_b(op_b), .store_data(store_data)
    );

    reg_file i_reg_file (
        .CK_REF(CK_REF), .RST_N(RST_N), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data)
    );

    alu i_alu (
        .CK_REF(CK_REF), .RST_N(RST_N), .ex_ctrl(ex_ctrl), .op_a(op_a), .op_b(op_b),
        .store_data(store_data), .mem_ctrl(mem_ctrl), .alu_result(alu_result),
        .mem_store_data(mem_store_data)
    );

    mem_wb_stage #(.MEM_AW(MEM_AW)) i_mem_wb (
        .CK_REF(CK_REF), .RST_N(RST_N), .mem_ctrl(mem_ctrl), .alu_result(alu_result),
        .mem_store_data(mem_store_data), .mem_read_wrn(mem_read_wrn), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
        .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f sim.f --top-module tb_rv_core -o tb_rv_core

./obj_dir/tb_rv_core > sim.log 2>&1
cat sim.log

if grep -qx "Simulation PASSED" sim.log; then
    echo "run_sim: testbench reported success"
    exit 0
fi
echo "run_sim: testbench reported failure"
exit 1

/* sim.f */
design/rv_core_pkg.sv
design/fetch_stage.sv
design/inst_decoder.sv
design/reg_file.sv
design/alu.sv
design/mem_wb_stage.sv
design/rv_core_top.sv
sim/tb_rv_core.sv

/* sim/tb_rv_core.sv */
`timescale 1ns/10ps

module tb_rv_core;

    localparam logic [31:0] RESET_PC   = 32'h0000_0200;      // Non-zero so the reset value shows
    localparam int          MEM_AW     = 16;
    localparam int          DMEM_WORDS = 2 ** (MEM_AW - 2);  // Word-addressed data array
    localparam logic [6:0]  OP_R       = 7'b011_0011;
    localparam logic [6:0]  OP_I       = 7'b001_0011;
    localparam logic [6:0]  OP_LD      = 7'b000_0011;
    localparam logic [6:0]  OP_ST      = 7'b010_0011;
    localparam logic [31:0] PAD_INST   = 32'h5a50_0013;      // addi x0, x0, 0x5a5

    // One program slot with what the data bus should show for it
    typedef struct packed {
        logic [31:0]       inst;
        logic              is_store;
        logic [MEM_AW-1:0] addr;
        logic [31:0]       data;
    } step_t;

    logic              CK_REF = 1'b0;
    logic              RST_N;
    logic [31:0]       inst_addr;
    logic [31:0]       inst_data;
    logic              mem_read_wrn;
    logic [MEM_AW-1:0] mem_addr;
    logic [31:0]       mem_wdata;
    logic [31:0]       mem_rdata;

    step_t       prog_q [$];                                 // Program table
    string       name_q [$];
    logic [31:0] xr [32];                                    // Expected register contents
    logic [31:0] dmem [DMEM_WORDS];
    logic [31:0] exp_pc;
    int          seed      = 32'h8446_f608;
    int          save_slot = 0;
    int          err_cnt   = 0;
    int          pass_cnt  = 0;
    int          pc_err    = 0;
    int          pc_cnt    = 0;
    int          cyc_cnt   = 0;                              // Cycles since reset release
    int          cyc_limit = 0;
    int          drain_at  = 0;

    rv_core_top #(
        .RESET_PC(RESET_PC),
        .MEM_AW  (MEM_AW)
    ) i_dut (
        .CK_REF      (CK_REF),
        .RST_N       (RST_N),
        .inst_addr   (inst_addr),
        .inst_data   (inst_data),
        .mem_read_wrn(mem_read_wrn),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata)
    );

    always #20 CK_REF = ~CK_REF;                             // 40 ns period

    // ********************
    // Instruction encoding
    // ********************
    function automatic logic [31:0] r_format(input logic [6:0] f7, input int rs2, input int rs1,
                                             input logic [2:0] f3, input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OP_R};
    endfunction

    function automatic logic [31:0] i_format(input int imm, input int rs1, input logic [2:0] f3,
                                             input int rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] s_format(input int imm, input int rs2, input int rs1,
                                             input logic [2:0] f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], OP_ST};
    endfunction

    function automatic logic [31:0] sext12(input int imm);
        return {{20{imm[11]}}, imm[11:0]};
    endfunction

    function automatic logic [31:0] sx8(input logic [31:0] w);
        return {{24{w[7]}}, w[7:0]};
    endfunction

    function automatic logic [31:0] zx8(input logic [31:0] w);
        return {24'h0, w[7:0]};
    endfunction

    function automatic logic [31:0] sx16(input logic [31:0] w);
        return {{16{w[15]}}, w[15:0]};
    endfunction

    function automatic logic [31:0] zx16(input logic [31:0] w);
        return {16'h0, w[15:0]};
    endfunction

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        return dmem[addr[MEM_AW-1:2]];                       // No byte lanes, whole word
    endfunction

    // First load offset from 0x100 whose word has the given sign bit set
    function automatic int neg_offset(input int start, input logic [31:0] sign_mask);
        int off;
        off = start;
        while (off < 2040 && (word_at(32'h100 + off) & sign_mask) == 32'h0) begin
            off += 4;
        end
        return off;
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        int idx;
        idx = int'((addr - RESET_PC) >> 2);
        if (idx >= 0 && idx < prog_q.size()) begin
            return prog_q[idx].inst;
        end
        return PAD_INST;                                     // Past the end runs on padding
    endfunction

    // ********************
    // Program building
    // ********************
    // Three pad slots after each real one keep any reader four behind its writer
    task automatic push(input logic [31:0] word, input logic st, input logic [31:0] addr,
                        input logic [31:0] data, input string name);
        step_t s;
        s.inst     = word;
        s.is_store = st;
        s.addr     = addr[MEM_AW-1:0];
        s.data     = data;
        prog_q.push_back(s);
        name_q.push_back(name);
        repeat (3) begin
            s      = '0;
            s.inst = PAD_INST;
            prog_q.push_back(s);
            name_q.push_back("pad");
        end
    endtask

    task automatic set_reg(input int rd, input logic [31:0] value);
        if (rd != 0) begin
            xr[rd] = value;                                  // x0 never changes
        end
    endtask

    task automatic op_reg(input logic [6:0] f7, input logic [2:0] f3, input int rd,
                          input int rs1, input int rs2, input logic [31:0] result);
        push(r_format(f7, rs2, rs1, f3, rd), 1'b0, 32'h0, 32'h0, "");
        set_reg(rd, result);
    endtask

    task automatic op_imm(input logic [2:0] f3, input int rd, input int rs1, input int imm,
                          input logic [31:0] result);
        push(i_format(imm, rs1, f3, rd, OP_I), 1'b0, 32'h0, 32'h0, "");
        set_reg(rd, result);
    endtask

    task automatic load(input logic [2:0] f3, input int rd, input int rs1, input int imm,
                        input logic [31:0] result);
        push(i_format(imm, rs1, f3, rd, OP_LD), 1'b0, 32'h0, 32'h0, "");
        set_reg(rd, result);
    endtask

    task automatic store(input logic [2:0] f3, input int rs2, input int rs1, input int imm,
                         input logic [31:0] data, input string name);
        push(s_format(imm, rs2, rs1, f3), 1'b1, xr[rs1] + sext12(imm), data, name);
    endtask

    task automatic save(input int rs, input string name);
        store(3'b010, rs, 6, save_slot * 4, xr[rs], name);   // SW into the result area
        save_slot++;
    endtask

    task automatic build_program();
        int b_off;
        int h_off;
        foreach (xr[i]) begin
            xr[i] = 32'h0;
        end
        b_off = neg_offset(8, 32'h0000_0080);                // Byte with its sign bit set
        h_off = neg_offset(12, 32'h0000_8000);               // Halfword with its sign bit set
        op_imm(3'b000, 5, 0, 'h100, 32'h0000_0100);          // Load base, never stored to
        op_imm(3'b000, 6, 0, 'h400, 32'h0000_0400);          // Store base
        op_imm(3'b000, 1, 0, -1234, 32'hffff_fb2e);
        op_imm(3'b000, 2, 0, 1447, 32'h0000_05a7);           // Low 5 bits are 7
        op_imm(3'b000, 7, 0, 'h0c3, 32'h0000_00c3);
        load(3'b010, 3, 5, 0, word_at(32'h100));             // Full-width random operands
        load(3'b010, 4, 5, 4, word_at(32'h104));
        op_reg(7'h00, 3'b000, 10, 1, 3, xr[1] + xr[3]);
        save(10, "add");
        op_reg(7'h20, 3'b000, 10, 1, 3, xr[1] - xr[3]);
        save(10, "sub");
        op_reg(7'h00, 3'b001, 10, 3, 2, xr[3] << 7);
        save(10, "sll");
        op_reg(7'h00, 3'b010, 10, 1, 2, 32'd1);              // Negative below positive
        save(10, "slt");
        op_reg(7'h00, 3'b011, 10, 1, 2, 32'd0);              // Same pair, unsigned view
        save(10, "sltu");
        op_reg(7'h00, 3'b100, 10, 3, 4, xr[3] ^ xr[4]);
        save(10, "xor");
        op_reg(7'h00, 3'b101, 10, 3, 4, xr[3] >> xr[4][4:0]);
        save(10, "srl");
        op_reg(7'h20, 3'b101, 10, 1, 2, 32'hffff_fff6);      // -1234 >>> 7
        save(10, "sra");
        op_reg(7'h00, 3'b110, 10, 1, 4, xr[1] | xr[4]);
        save(10, "or");
        op_reg(7'h00, 3'b111, 10, 3, 4, xr[3] & xr[4]);
        save(10, "and");
        op_imm(3'b000, 10, 3, -2048, xr[3] + 32'hffff_f800);
        save(10, "addi");
        op_imm(3'b010, 10, 1, -1000, 32'd1);
        save(10, "slti neg");
        op_imm(3'b010, 10, 2, -1000, 32'd0);
        save(10, "slti pos");
        op_imm(3'b011, 10, 1, -1, 32'd1);                    // Compares against 0xffffffff
        save(10, "sltiu");
        op_imm(3'b100, 10, 3, -2048, xr[3] ^ 32'hffff_f800);
        save(10, "xori");
        op_imm(3'b110, 10, 1, 'h0f0, 32'hffff_fbfe);
        save(10, "ori");
        op_imm(3'b111, 10, 3, 'h7ff, xr[3] & 32'h0000_07ff);
        save(10, "andi");
        op_imm(3'b001, 10, 3, 13, xr[3] << 13);
        save(10, "slli");
        op_imm(3'b101, 10, 1, 9, 32'h007f_fffd);
        save(10, "srli");
        op_imm(3'b101, 10, 1, 'h409, 32'hffff_fffd);         // Bit 30 set
        save(10, "srai");
        load(3'b000, 11, 5, b_off, sx8(word_at(32'h100 + b_off)));
        save(11, "lb");
        load(3'b100, 11, 5, b_off, zx8(word_at(32'h100 + b_off)));
        save(11, "lbu");
        load(3'b001, 11, 5, h_off, sx16(word_at(32'h100 + h_off)));
        save(11, "lh");
        load(3'b101, 11, 5, h_off, zx16(word_at(32'h100 + h_off)));
        save(11, "lhu");
        load(3'b010, 11, 5, 16, word_at(32'h110));
        save(11, "lw");
        store(3'b000, 7, 6, 'h200, 32'hffff_ffc3, "sb neg");
        store(3'b000, 1, 6, 'h204, 32'h0000_002e, "sb pos");
        store(3'b001, 1, 6, 'h208, 32'hffff_fb2e, "sh neg");
        store(3'b001, 2, 6, 'h20c, 32'h0000_05a7, "sh pos");
        store(3'b010, 3, 6, -4, xr[3], "sw neg offset");
        op_imm(3'b000, 0, 1, 77, 32'h0);                     // Write to x0 is dropped
        save(0, "x0");
    endtask

    // ********************
    // Memory model
    // ********************
    initial begin
        inst_data = 32'h0;
        mem_rdata = 32'h0;
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = $random(seed);
        end
        forever begin
            @(posedge CK_REF);
            #1;
            inst_data = fetch_word(inst_addr);
            if (!mem_read_wrn) begin
                dmem[mem_addr[MEM_AW-1:2]] = mem_wdata;
            end
            mem_rdata = dmem[mem_addr[MEM_AW-1:2]];
        end
    end

    always @(posedge CK_REF) begin
        if (RST_N) begin
            cyc_cnt++;
        end
        if (cyc_cnt > cyc_limit) begin
            $display("Timeout: the program did not finish within %0d cycles", cyc_limit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // Mid-cycle sample point, PC must step by 4 every cycle
    task automatic next_cycle();
        @(negedge CK_REF);
        pc_cnt++;
        if (inst_addr !== exp_pc) begin
            $display("[ERROR] inst_addr: got 0x%h expected 0x%h", inst_addr, exp_pc);
            err_cnt++;
            pc_err++;
        end
        exp_pc = exp_pc + 32'd4;
    endtask

    task automatic wait_store(output logic found);
        found = 1'b0;
        while (!found && cyc_cnt < drain_at) begin
            next_cycle();
            if (!mem_read_wrn) begin
                found = 1'b1;
            end
        end
    endtask

    // ********************
    // Main sequence
    // ********************
    initial begin
        logic found;
        logic bad;
        int   store_no;
        RST_N = 1'b0;
        #1;
        build_program();
        cyc_limit = prog_q.size() + 20;
        drain_at  = prog_q.size() + 8;                       // Last store is on the bus by then
        exp_pc    = RESET_PC;
        store_no  = 0;

        @(negedge CK_REF);
        bad = 1'b0;
        if (inst_addr !== RESET_PC) begin
            $display("[ERROR] inst_addr: got 0x%h expected 0x%h", inst_addr, RESET_PC);
            bad = 1'b1;
        end
        if (mem_read_wrn !== 1'b1) begin
            $display("[ERROR] mem_read_wrn: got 0x%h expected 0x1", mem_read_wrn);
            bad = 1'b1;
        end
        if (mem_addr !== '0 || mem_wdata !== 32'h0) begin
            $display("[ERROR] mem_addr/mem_wdata: got 0x%h/0x%h expected 0x0/0x0",
                     mem_addr, mem_wdata);
            bad = 1'b1;
        end
        if (bad) begin
            err_cnt++;
        end else begin
            pass_cnt++;
            $display("reset: bus idle, inst_addr 0x%h ok", inst_addr);
        end
        @(posedge CK_REF);
        #1;
        RST_N = 1'b1;

        for (int k = 0; k < prog_q.size(); k++) begin
            if (prog_q[k].is_store) begin
                wait_store(found);
                bad = 1'b0;
                if (!found) begin
                    $display("Store %0d (%s) never showed up on the data bus", store_no, name_q[k]);
                    bad = 1'b1;
                end else begin
                    if (mem_addr !== prog_q[k].addr) begin
                        $display("[ERROR] mem_addr (%s): got 0x%h expected 0x%h",
                                 name_q[k], mem_addr, prog_q[k].addr);
                        bad = 1'b1;
                    end
                    if (mem_wdata !== prog_q[k].data) begin
                        $display("[ERROR] mem_wdata (%s): got 0x%h expected 0x%h",
                                 name_q[k], mem_wdata, prog_q[k].data);
                        bad = 1'b1;
                    end
                end
                if (bad) begin
                    err_cnt++;
                end else begin
                    pass_cnt++;
                    $display("store %0d %s: addr 0x%h data 0x%h ok",
                             store_no, name_q[k], mem_addr, mem_wdata);
                end
                store_no++;
            end
        end

        // Anything written after the last expected store is extra
        while (cyc_cnt < drain_at) begin
            next_cycle();
            if (!mem_read_wrn) begin
                $display("Unexpected extra store on the data bus at address 0x%h", mem_addr);
                err_cnt++;
            end
        end
        if (pc_err == 0) begin
            pass_cnt++;
            $display("inst_addr: stepped by 4 over %0d cycles ok", pc_cnt);
        end

        $display("Tests passed: %0d, errors: %0d", pass_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
